/* hdl/dbg_consts.svh */
//////////////////////////////////////////////////
// debug front end widths, JTAG ID and IR codes
//////////////////////////////////////////////////
`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

// DMI address width
`define DBG_ABITS 7

// DMI data and system bus width
`define DBG_XLEN 32

// JTAG ID, bit 0 must be set
`define DBG_IDCODE 32'h1e5d_b001

// instruction register codes, 5 bits
`define IR_IDCODE 5'h01
`define IR_DTMCS 5'h10
`define IR_DMI 5'h11

`endif

/* hdl/dbg_pkg.sv */
//////////////////////////////////////////////////
// debug front end types
// DMI ops and status, DM register map, sbcs layout
//////////////////////////////////////////////////
`include "dbg_consts.svh"

package dbg_pkg;

	typedef enum logic [1:0] {
		DMI_OP_NOP = 2'd0,
		DMI_OP_READ = 2'd1,
		DMI_OP_WRITE = 2'd2
	} dmi_op_t;

	// failed and busy follow the debug spec encoding
	typedef enum logic [1:0] {
		DMI_STAT_OK = 2'd0,
		DMI_STAT_FAILED = 2'd2,
		DMI_STAT_BUSY = 2'd3
	} dmi_stat_t;

	typedef enum logic [`DBG_ABITS-1:0] {
		ADDR_DATA0 = 7'h04,
		ADDR_DMCONTROL = 7'h10,
		ADDR_DMSTATUS = 7'h11,
		ADDR_SBCS = 7'h38,
		ADDR_SBADDRESS0 = 7'h39,
		ADDR_SBDATA0 = 7'h3c
	} dm_addr_t;

	typedef struct packed {
		logic [2:0] sbversion;
		logic [5:0] rsvd;
		logic sbbusyerror;
		logic sbbusy;
		logic sbreadonaddr;
		logic [2:0] sbaccess;
		logic sbautoincrement;
		logic sbreadondata;
		logic [2:0] sberror;
		logic [6:0] sbasize;
		logic [4:0] sbaccess_sizes;
	} sbcs_t;

endpackage

/* hdl/dmi_if.sv */
//////////////////////////////////////////////////
// DMI bundle between DTM and DM, APB style
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "dbg_consts.svh"

interface dmi_if;

	logic psel;
	logic penable;
	logic pwrite;
	logic [`DBG_ABITS-1:0] paddr;
	logic [`DBG_XLEN-1:0] pwdata;
	logic [`DBG_XLEN-1:0] prdata;
	logic pready;
	logic pslverr;

	modport dtm (
		output psel, penable, pwrite, paddr, pwdata,
		input prdata, pready, pslverr
	);

	modport dm (
		input psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

/* hdl/dbg_reset_sync.sv */
//////////////////////////////////////////////////
// reset synchronizer, async assert, sync release
//////////////////////////////////////////////////
`timescale 1ns/10ps

module dbg_reset_sync (
	input logic clk,
	input logic i_rst_n,
	output logic o_rst_n
);

	logic [1:0] sync_q;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign o_rst_n = sync_q[1];

	// release only after two clean input cycles
	a_release_late: assert property (@(posedge clk)
		$rose(o_rst_n) |-> $past(i_rst_n) && $past(i_rst_n, 2));

endmodule

/* hdl/jtag_dtm.sv */
//////////////////////////////////////////////////
// JTAG DTM, oversampled TAP with IDCODE/DTMCS/DMI
// and the APB style DMI request master
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "dbg_consts.svh"

module jtag_dtm (
	input logic clk,
	input logic rst_n,
	input logic i_tck,
	input logic i_tms,
	input logic i_tdi,
	input logic i_trst_n,
	output logic o_tdo,
	output logic o_dmihardreset,
	dmi_if.dtm dmi
);

	localparam int DMI_W = `DBG_ABITS + `DBG_XLEN + 2;

	typedef enum logic [3:0] {
		TAP_RESET, TAP_IDLE,
		DR_SELECT, DR_CAPTURE, DR_SHIFT, DR_EXIT1, DR_PAUSE, DR_EXIT2, DR_UPDATE,
		IR_SELECT, IR_CAPTURE, IR_SHIFT, IR_EXIT1, IR_PAUSE, IR_EXIT2, IR_UPDATE
	} tap_state_t;

	logic [3:0] pin_s0;
	logic [3:0] pin_s1;
	logic tck_d;
	logic tck_rise;
	logic tck_fall;
	logic tms_s;
	logic tdi_s;
	logic trst_s;
	tap_state_t state;
	tap_state_t state_nxt;
	logic [4:0] ir;
	logic [4:0] ir_shift;
	logic [DMI_W-1:0] dr_shift;
	logic [31:0] dtmcs_val;
	logic req_go;
	logic req_pend;
	logic dmi_upd;
	logic [`DBG_XLEN-1:0] resp_data;
	dbg_pkg::dmi_stat_t resp_stat;
	dbg_pkg::dmi_stat_t cap_stat;
	dbg_pkg::dmi_op_t upd_op;

	// pins in order trst_n, tck, tms, tdi
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pin_s0 <= 4'b0000;
			pin_s1 <= 4'b0000;
			tck_d <= 1'b0;
		end else begin
			pin_s0 <= {i_trst_n, i_tck, i_tms, i_tdi};
			pin_s1 <= pin_s0;
			tck_d <= pin_s1[2];
		end
	end

	assign trst_s = pin_s1[3];
	assign tms_s = pin_s1[1];
	assign tdi_s = pin_s1[0];
	assign tck_rise = pin_s1[2] & ~tck_d;
	assign tck_fall = ~pin_s1[2] & tck_d;

	always_comb begin
		case (state)
			TAP_RESET: state_nxt = tms_s ? TAP_RESET : TAP_IDLE;
			TAP_IDLE: state_nxt = tms_s ? DR_SELECT : TAP_IDLE;
			DR_SELECT: state_nxt = tms_s ? IR_SELECT : DR_CAPTURE;
			DR_CAPTURE: state_nxt = tms_s ? DR_EXIT1 : DR_SHIFT;
			DR_SHIFT: state_nxt = tms_s ? DR_EXIT1 : DR_SHIFT;
			DR_EXIT1: state_nxt = tms_s ? DR_UPDATE : DR_PAUSE;
			DR_PAUSE: state_nxt = tms_s ? DR_EXIT2 : DR_PAUSE;
			DR_EXIT2: state_nxt = tms_s ? DR_UPDATE : DR_SHIFT;
			DR_UPDATE: state_nxt = tms_s ? DR_SELECT : TAP_IDLE;
			IR_SELECT: state_nxt = tms_s ? TAP_RESET : IR_CAPTURE;
			IR_CAPTURE: state_nxt = tms_s ? IR_EXIT1 : IR_SHIFT;
			IR_SHIFT: state_nxt = tms_s ? IR_EXIT1 : IR_SHIFT;
			IR_EXIT1: state_nxt = tms_s ? IR_UPDATE : IR_PAUSE;
			IR_PAUSE: state_nxt = tms_s ? IR_EXIT2 : IR_PAUSE;
			IR_EXIT2: state_nxt = tms_s ? IR_UPDATE : IR_SHIFT;
			default: state_nxt = tms_s ? DR_SELECT : TAP_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TAP_RESET;
			ir <= `IR_IDCODE;
		end else if (!trst_s) begin
			state <= TAP_RESET;
			ir <= `IR_IDCODE;
		end else if (tck_rise) begin
			state <= state_nxt;
			if (state == TAP_RESET)
				ir <= `IR_IDCODE;
			else if (state == IR_UPDATE)
				ir <= ir_shift;
		end
	end

	// version 1, abits, idle hint of 1
	assign dtmcs_val = {14'b0, 2'b00, 1'b0, 3'd1, resp_stat, 6'(`DBG_ABITS), 4'd1};
	assign cap_stat = req_pend ? dbg_pkg::DMI_STAT_BUSY : resp_stat;

	always_ff @(posedge clk) begin
		if (tck_rise && state == IR_CAPTURE)
			ir_shift <= 5'b00001;
		else if (tck_rise && state == IR_SHIFT)
			ir_shift <= {tdi_s, ir_shift[4:1]};
		if (tck_rise && state == DR_CAPTURE) begin
			case (ir)
				`IR_IDCODE: dr_shift <= DMI_W'(`DBG_IDCODE);
				`IR_DTMCS: dr_shift <= DMI_W'(dtmcs_val);
				`IR_DMI: dr_shift <= {dmi.paddr, resp_data, cap_stat};
				default: dr_shift <= '0;
			endcase
		end else if (tck_rise && state == DR_SHIFT) begin
			case (ir)
				`IR_DMI: dr_shift <= {tdi_s, dr_shift[DMI_W-1:1]};
				`IR_IDCODE, `IR_DTMCS: dr_shift <= {{(DMI_W-32){1'b0}}, tdi_s, dr_shift[31:1]};
				// bypass
				default: dr_shift <= {{(DMI_W-1){1'b0}}, tdi_s};
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_tdo <= 1'b1;
		else if (tck_fall) begin
			if (state == IR_SHIFT)
				o_tdo <= ir_shift[0];
			else if (state == DR_SHIFT)
				o_tdo <= dr_shift[0];
			else
				o_tdo <= 1'b1;
		end
	end

	assign upd_op = dbg_pkg::dmi_op_t'(dr_shift[1:0]);
	assign dmi_upd = tck_fall && state == DR_UPDATE && ir == `IR_DMI;

	// DMI request master
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_go <= 1'b0;
			req_pend <= 1'b0;
			resp_stat <= dbg_pkg::DMI_STAT_OK;
			o_dmihardreset <= 1'b0;
			dmi.psel <= 1'b0;
			dmi.penable <= 1'b0;
			dmi.pwrite <= 1'b0;
		end else begin
			req_go <= 1'b0;
			o_dmihardreset <= 1'b0;
			if (tck_fall && state == DR_UPDATE && ir == `IR_DTMCS) begin
				// dmireset bit 16, dmihardreset bit 17
				if (dr_shift[16] || dr_shift[17])
					resp_stat <= dbg_pkg::DMI_STAT_OK;
				if (dr_shift[17]) begin
					o_dmihardreset <= 1'b1;
					req_pend <= 1'b0;
					dmi.psel <= 1'b0;
					dmi.penable <= 1'b0;
				end
			end else if (dmi_upd) begin
				if (req_pend)
					resp_stat <= dbg_pkg::DMI_STAT_BUSY;
				else if (resp_stat != dbg_pkg::DMI_STAT_BUSY &&
						(upd_op == dbg_pkg::DMI_OP_READ || upd_op == dbg_pkg::DMI_OP_WRITE)) begin
					req_go <= 1'b1;
					req_pend <= 1'b1;
					dmi.pwrite <= upd_op == dbg_pkg::DMI_OP_WRITE;
				end
			end else if (req_go) begin
				dmi.psel <= 1'b1;
			end else if (dmi.psel && !dmi.penable) begin
				dmi.penable <= 1'b1;
			end else if (dmi.penable && dmi.pready) begin
				dmi.psel <= 1'b0;
				dmi.penable <= 1'b0;
				req_pend <= 1'b0;
				// sticky busy wins until dmireset
				if (resp_stat != dbg_pkg::DMI_STAT_BUSY)
					resp_stat <= dmi.pslverr ? dbg_pkg::DMI_STAT_FAILED : dbg_pkg::DMI_STAT_OK;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dmi_upd && !req_pend) begin
			dmi.paddr <= dr_shift[DMI_W-1 -: `DBG_ABITS];
			dmi.pwdata <= dr_shift[`DBG_XLEN+1:2];
		end
		if (dmi.penable && dmi.pready)
			resp_data <= dmi.prdata;
	end

	a_penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dmi.penable) |-> $past(dmi.psel) && dmi.psel);
	a_paddr_held: assert property (@(posedge clk) disable iff (!rst_n)
		dmi.psel && !(dmi.penable && dmi.pready) |=> $stable(dmi.paddr));

endmodule

/* hdl/debug_module.sv */
//////////////////////////////////////////////////
// debug module, one hart, system bus access
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "dbg_consts.svh"

module debug_module (
	input logic clk,
	input logic rst_n,
	dmi_if.dm dmi,
	output logic o_halt_req,
	output logic o_resume_req,
	output logic o_ndmreset,
	input logic i_halted,
	input logic i_running,
	output logic [`DBG_XLEN-1:0] o_sb_addr,
	output logic [`DBG_XLEN-1:0] o_sb_wdata,
	output logic o_sb_write,
	output logic o_sb_vld,
	input logic i_sb_rdy,
	input logic [`DBG_XLEN-1:0] i_sb_rdata,
	input logic i_sb_err
);

	dbg_pkg::dm_addr_t addr;
	dbg_pkg::sbcs_t sbcs_rd;
	dbg_pkg::sbcs_t sbcs_wr;
	logic [`DBG_XLEN-1:0] data0;
	logic [31:0] dmstatus;
	logic dmactive;
	logic resumeack;
	logic sbbusy;
	logic sbreadonaddr;
	logic sbreadondata;
	logic [2:0] sbaccess;
	logic [2:0] sberror;
	logic acc;
	logic wr;
	logic rd;
	logic hit;
	logic sb_stall;
	logic sb_start;

	assign addr = dbg_pkg::dm_addr_t'(dmi.paddr);
	assign sbcs_wr = dbg_pkg::sbcs_t'(dmi.pwdata);
	assign acc = dmi.psel && dmi.penable;
	// sb data/address accesses wait while the bus is busy
	assign sb_stall = sbbusy &&
		(addr == dbg_pkg::ADDR_SBADDRESS0 || addr == dbg_pkg::ADDR_SBDATA0);
	assign dmi.pready = !sb_stall;
	assign dmi.pslverr = acc && !hit;
	assign wr = acc && dmi.pready && dmi.pwrite;
	assign rd = acc && dmi.pready && !dmi.pwrite;

	assign sb_start = sberror == 3'd0 && (
		(wr && addr == dbg_pkg::ADDR_SBDATA0) ||
		(wr && addr == dbg_pkg::ADDR_SBADDRESS0 && sbreadonaddr) ||
		(rd && addr == dbg_pkg::ADDR_SBDATA0 && sbreadondata));

	// all and any bits agree with a single hart
	assign dmstatus = {14'b0, resumeack, resumeack, 4'b0, i_running, i_running,
		i_halted, i_halted, 1'b1, 3'b0, 4'd2};

	always_comb begin
		sbcs_rd = '0;
		sbcs_rd.sbversion = 3'd1;
		sbcs_rd.sbbusy = sbbusy;
		sbcs_rd.sbreadonaddr = sbreadonaddr;
		sbcs_rd.sbaccess = sbaccess;
		sbcs_rd.sbreadondata = sbreadondata;
		sbcs_rd.sberror = sberror;
		sbcs_rd.sbasize = 7'(`DBG_XLEN);
		sbcs_rd.sbaccess_sizes = 5'b00100;
	end

	always_comb begin
		hit = 1'b1;
		dmi.prdata = '0;
		case (addr)
			dbg_pkg::ADDR_DATA0: dmi.prdata = data0;
			dbg_pkg::ADDR_DMCONTROL:
				dmi.prdata = {o_halt_req, o_resume_req, 28'b0, o_ndmreset, dmactive};
			dbg_pkg::ADDR_DMSTATUS: dmi.prdata = dmstatus;
			dbg_pkg::ADDR_SBCS: dmi.prdata = sbcs_rd;
			dbg_pkg::ADDR_SBADDRESS0: dmi.prdata = o_sb_addr;
			dbg_pkg::ADDR_SBDATA0: dmi.prdata = o_sb_wdata;
			default: hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dmactive <= 1'b0;
			o_halt_req <= 1'b0;
			o_resume_req <= 1'b0;
			o_ndmreset <= 1'b0;
			resumeack <= 1'b0;
			sbbusy <= 1'b0;
			sbreadonaddr <= 1'b0;
			sbreadondata <= 1'b0;
			sbaccess <= 3'd2;
			sberror <= 3'd0;
			o_sb_write <= 1'b0;
		end else begin
			if (wr && addr == dbg_pkg::ADDR_DMCONTROL) begin
				o_halt_req <= dmi.pwdata[31];
				o_ndmreset <= dmi.pwdata[1];
				dmactive <= dmi.pwdata[0];
				if (dmi.pwdata[30] && !dmi.pwdata[31]) begin
					o_resume_req <= 1'b1;
					resumeack <= 1'b0;
				end
			end else if (o_resume_req && i_running) begin
				o_resume_req <= 1'b0;
				resumeack <= 1'b1;
			end
			if (wr && addr == dbg_pkg::ADDR_SBCS) begin
				sbreadonaddr <= sbcs_wr.sbreadonaddr;
				sbreadondata <= sbcs_wr.sbreadondata;
				sbaccess <= sbcs_wr.sbaccess;
				sberror <= sberror & ~sbcs_wr.sberror;
			end
			if (sb_start) begin
				sbbusy <= 1'b1;
				o_sb_write <= dmi.pwrite && addr == dbg_pkg::ADDR_SBDATA0;
			end else if (sbbusy && i_sb_rdy) begin
				sbbusy <= 1'b0;
				if (i_sb_err)
					sberror <= 3'd2;
			end
		end
	end

	assign o_sb_vld = sbbusy;

	// sbdata0 doubles as write data and read result
	always_ff @(posedge clk) begin
		if (wr && addr == dbg_pkg::ADDR_DATA0)
			data0 <= dmi.pwdata;
		if (wr && addr == dbg_pkg::ADDR_SBADDRESS0)
			o_sb_addr <= dmi.pwdata;
		if (wr && addr == dbg_pkg::ADDR_SBDATA0)
			o_sb_wdata <= dmi.pwdata;
		else if (sbbusy && i_sb_rdy && !i_sb_err && !o_sb_write)
			o_sb_wdata <= i_sb_rdata;
	end

	a_rdy_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		i_sb_rdy |-> sbbusy);
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		o_sb_vld && !i_sb_rdy |=> o_sb_vld && $stable(o_sb_addr));

endmodule

/* hdl/sba_wb_master.sv */
//////////////////////////////////////////////////
// Wishbone classic master for one system bus access
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "dbg_consts.svh"

module sba_wb_master (
	input logic clk,
	input logic rst_n,
	input logic [`DBG_XLEN-1:0] i_sb_addr,
	input logic [`DBG_XLEN-1:0] i_sb_wdata,
	input logic i_sb_write,
	input logic i_sb_vld,
	output logic o_sb_rdy,
	output logic [`DBG_XLEN-1:0] o_sb_rdata,
	output logic o_sb_err,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output logic [`DBG_XLEN-1:0] o_wb_adr,
	output logic [`DBG_XLEN-1:0] o_wb_dat,
	output logic [`DBG_XLEN/8-1:0] o_wb_sel,
	input logic i_wb_ack,
	input logic i_wb_err,
	input logic [`DBG_XLEN-1:0] i_wb_dat
);

	typedef enum logic [1:0] {WB_IDLE, WB_BUS, WB_RESP} wb_state_t;

	wb_state_t state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= WB_IDLE;
			o_sb_err <= 1'b0;
		end else begin
			case (state)
				WB_IDLE: if (i_sb_vld) state <= WB_BUS;
				WB_BUS: if (i_wb_ack || i_wb_err) begin
					state <= WB_RESP;
					o_sb_err <= i_wb_err;
				end
				default: state <= WB_IDLE;
			endcase
		end
	end

	// request registered on acceptance
	always_ff @(posedge clk) begin
		if (state == WB_IDLE && i_sb_vld) begin
			o_wb_adr <= i_sb_addr;
			o_wb_dat <= i_sb_wdata;
			o_wb_we <= i_sb_write;
		end
		if (state == WB_BUS && i_wb_ack)
			o_sb_rdata <= i_wb_dat;
	end

	assign o_wb_cyc = state == WB_BUS;
	assign o_wb_stb = state == WB_BUS;
	assign o_wb_sel = {(`DBG_XLEN/8){1'b1}};
	assign o_sb_rdy = state == WB_RESP;

	a_term_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		i_wb_ack || i_wb_err |-> o_wb_cyc && o_wb_stb);
	a_cyc_ends_on_term: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(o_wb_cyc) |-> $past(i_wb_ack || i_wb_err));

endmodule

/* hdl/dbg_top.sv */
//////////////////////////////////////////////////
// debug front end top, JTAG in, Wishbone out
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "dbg_consts.svh"

module dbg_top (
	input logic clk,
	input logic rst_n,
	input logic i_tck,
	input logic i_tms,
	input logic i_tdi,
	input logic i_trst_n,
	output logic o_tdo,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output logic [`DBG_XLEN-1:0] o_wb_adr,
	output logic [`DBG_XLEN-1:0] o_wb_dat,
	output logic [`DBG_XLEN/8-1:0] o_wb_sel,
	input logic i_wb_ack,
	input logic i_wb_err,
	input logic [`DBG_XLEN-1:0] i_wb_dat,
	output logic o_halt_req,
	output logic o_resume_req,
	output logic o_hart_reset,
	input logic i_halted,
	input logic i_running
);

	logic dmihardreset;
	logic rst_n_dm;
	logic ndmreset;
	logic rst_n_hart;
	logic [`DBG_XLEN-1:0] sb_addr;
	logic [`DBG_XLEN-1:0] sb_wdata;
	logic [`DBG_XLEN-1:0] sb_rdata;
	logic sb_write;
	logic sb_vld;
	logic sb_rdy;
	logic sb_err;

	dmi_if dmi ();

	// DM and bus master domain, also cleared by dmihardreset
	dbg_reset_sync u_dm_rst (
		.clk (clk),
		.i_rst_n (rst_n && !dmihardreset),
		.o_rst_n (rst_n_dm)
	);

	dbg_reset_sync u_hart_rst (
		.clk (clk),
		.i_rst_n (rst_n && !ndmreset),
		.o_rst_n (rst_n_hart)
	);

	assign o_hart_reset = !rst_n_hart;

	jtag_dtm u_dtm (
		.clk (clk),
		.rst_n (rst_n),
		.i_tck (i_tck),
		.i_tms (i_tms),
		.i_tdi (i_tdi),
		.i_trst_n (i_trst_n),
		.o_tdo (o_tdo),
		.o_dmihardreset (dmihardreset),
		.dmi (dmi)
	);

	debug_module u_dm (
		.clk (clk),
		.rst_n (rst_n_dm),
		.dmi (dmi),
		.o_halt_req (o_halt_req),
		.o_resume_req (o_resume_req),
		.o_ndmreset (ndmreset),
		.i_halted (i_halted),
		.i_running (i_running),
		.o_sb_addr (sb_addr),
		.o_sb_wdata (sb_wdata),
		.o_sb_write (sb_write),
		.o_sb_vld (sb_vld),
		.i_sb_rdy (sb_rdy),
		.i_sb_rdata (sb_rdata),
		.i_sb_err (sb_err)
	);

	sba_wb_master u_sba (
		.clk (clk),
		.rst_n (rst_n_dm),
		.i_sb_addr (sb_addr),
		.i_sb_wdata (sb_wdata),
		.i_sb_write (sb_write),
		.i_sb_vld (sb_vld),
		.o_sb_rdy (sb_rdy),
		.o_sb_rdata (sb_rdata),
		.o_sb_err (sb_err),
		.o_wb_cyc (o_wb_cyc),
		.o_wb_stb (o_wb_stb),
		.o_wb_we (o_wb_we),
		.o_wb_adr (o_wb_adr),
		.o_wb_dat (o_wb_dat),
		.o_wb_sel (o_wb_sel),
		.i_wb_ack (i_wb_ack),
		.i_wb_err (i_wb_err),
		.i_wb_dat (i_wb_dat)
	);

endmodule

/* test/tb_dbg_top.sv */
//////////////////////////////////////////////////
// debug front end testbench, JTAG driver, hart and
// Wishbone memory models, DMI pattern player
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "dbg_consts.svh"

module tb_dbg_top;

	localparam int MAX_PAT = 64;
	localparam int TCK_HALF = 5;
	localparam int CYC_PER_PAT = 2000;

	logic clk;
	logic rst_n;
	logic i_tck;
	logic i_tms;
	logic i_tdi;
	logic i_trst_n;
	logic o_tdo;
	logic o_wb_cyc;
	logic o_wb_stb;
	logic o_wb_we;
	logic [`DBG_XLEN-1:0] o_wb_adr;
	logic [`DBG_XLEN-1:0] o_wb_dat;
	logic [`DBG_XLEN/8-1:0] o_wb_sel;
	logic i_wb_ack = 1'b0;
	logic i_wb_err = 1'b0;
	logic [`DBG_XLEN-1:0] i_wb_dat = '0;
	logic o_halt_req;
	logic o_resume_req;
	logic o_hart_reset;
	logic i_halted = 1'b0;
	logic i_running = 1'b0;

	logic [31:0] pat_mem [0:MAX_PAT*5-1];
	logic [31:0] mem [0:255];
	int n_pat = 0;
	int errors = 0;
	int checks = 0;
	logic [15:0] lfsr = 16'd49;
	int wait_left = -1;
	logic [3:0] halt_pipe = 4'b0000;
	logic resume_seen = 1'b0;
	logic [31:0] wb_last_adr = '0;
	logic [31:0] wb_last_dat = '0;
	logic wb_last_we = 1'b0;

	dbg_top DUT (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_wait(output int n);
		int i;
		n = 0;
		for (i = 0; i < 2; i++) begin
			lfsr = lfsr_step(lfsr);
			n = n * 2 + int'(lfsr[0]);
		end
	endtask

	// hart stand-in
	always @(negedge clk) begin
		if (!rst_n) begin
			halt_pipe = 4'b0000;
			resume_seen = 1'b0;
		end else begin
			halt_pipe = {halt_pipe[2:0], o_halt_req};
			if (o_resume_req)
				resume_seen = 1'b1;
		end
		i_halted = halt_pipe[3];
		i_running = resume_seen && !halt_pipe[3];
	end

	task automatic wb_respond();
		int idx;
		idx = int'(o_wb_adr[9:2]);
		if (o_wb_adr >= 32'h0000_8000) begin
			i_wb_err = 1'b1;
		end else begin
			i_wb_ack = 1'b1;
			checks++;
			if (o_wb_sel != 4'hf) begin
				errors++;
				$display("ERR %0t: wb sel %h, expected f", $time, o_wb_sel);
			end
			wb_last_adr = o_wb_adr;
			wb_last_dat = o_wb_dat;
			wb_last_we = o_wb_we;
			if (o_wb_we)
				mem[idx] = o_wb_dat;
			else
				i_wb_dat = mem[idx];
		end
	endtask

	// Wishbone memory with 0 to 3 wait states
	always @(negedge clk) begin
		i_wb_ack = 1'b0;
		i_wb_err = 1'b0;
		if (!rst_n) begin
			wait_left = -1;
		end else if (o_wb_cyc && o_wb_stb) begin
			if (wait_left < 0)
				draw_wait(wait_left);
			if (wait_left > 0) begin
				wait_left--;
			end else begin
				wait_left = -1;
				wb_respond();
			end
		end
	end

	// one TCK period of 10 clk, TDO sampled before the rising edge
	task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
		i_tms = tms;
		i_tdi = tdi;
		repeat (TCK_HALF) @(negedge clk);
		tdo = o_tdo;
		i_tck = 1'b1;
		repeat (TCK_HALF) @(negedge clk);
		i_tck = 1'b0;
	endtask

	task automatic run_idle(input int n);
		logic t;
		int i;
		for (i = 0; i < n; i++)
			jtag_clock(1'b0, 1'b0, t);
	endtask

	task automatic tap_reset();
		logic t;
		int i;
		for (i = 0; i < 5; i++)
			jtag_clock(1'b1, 1'b0, t);
		jtag_clock(1'b0, 1'b0, t);
	endtask

	task automatic shift_ir(input logic [4:0] code);
		logic t;
		int i;
		jtag_clock(1'b1, 1'b0, t);
		jtag_clock(1'b1, 1'b0, t);
		jtag_clock(1'b0, 1'b0, t);
		jtag_clock(1'b0, 1'b0, t);
		for (i = 0; i < 5; i++)
			jtag_clock(i == 4, code[i], t);
		jtag_clock(1'b1, 1'b0, t);
		jtag_clock(1'b0, 1'b0, t);
	endtask

	// idle to idle through capture, shift and update
	task automatic shift_dr(input logic [40:0] din, input int len, output logic [40:0] dout);
		logic t;
		int i;
		dout = '0;
		jtag_clock(1'b1, 1'b0, t);
		jtag_clock(1'b0, 1'b0, t);
		jtag_clock(1'b0, 1'b0, t);
		for (i = 0; i < len; i++) begin
			jtag_clock(i == len - 1, din[i], t);
			dout[i] = t;
		end
		jtag_clock(1'b1, 1'b0, t);
		jtag_clock(1'b0, 1'b0, t);
	endtask

	// dtms dmireset clears the sticky busy
	task automatic dmi_reset();
		logic [40:0] dout;
		shift_ir(`IR_DTMCS);
		shift_dr({9'b0, 32'h0001_0000}, 32, dout);
		shift_ir(`IR_DMI);
	endtask

	task automatic dmi_result(output logic [31:0] data, output logic [1:0] stat);
		logic [40:0] dout;
		int tries;
		tries = 0;
		run_idle(4);
		shift_dr('0, 41, dout);
		while (dout[1:0] == dbg_pkg::DMI_STAT_BUSY && tries < 8) begin
			dmi_reset();
			run_idle(4);
			shift_dr('0, 41, dout);
			tries++;
		end
		if (dout[1:0] == dbg_pkg::DMI_STAT_BUSY) begin
			errors++;
			$display("DMI still busy after %0d retries at %0t", tries, $time);
		end
		data = dout[33:2];
		stat = dout[1:0];
	endtask

	task automatic run_pattern(input int p);
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_data;
		logic [31:0] exp_stat;
		logic [40:0] dout;
		logic [31:0] rdata;
		logic [1:0] rstat;
		op = pat_mem[p*5];
		addr = pat_mem[p*5+1];
		data = pat_mem[p*5+2];
		exp_data = pat_mem[p*5+3];
		exp_stat = pat_mem[p*5+4];
		case (op)
			32'd1, 32'd2: begin
				shift_dr({addr[`DBG_ABITS-1:0], data, op[1:0]}, 41, dout);
				dmi_result(rdata, rstat);
				checks++;
				if (rstat != exp_stat[1:0]) begin
					errors++;
					$display("ERR %0t: pattern %0d addr %h status %0d, expected %0d",
						$time, p, addr, rstat, exp_stat);
				end
				// a write returns the old register value, so only reads compare data
				if (op == 32'd1) begin
					checks++;
					if (rdata != exp_data) begin
						errors++;
						$display("ERR %0t: pattern %0d addr %h read %h, expected %h",
							$time, p, addr, rdata, exp_data);
					end
				end
			end
			32'd3: begin
				checks++;
				if ({29'b0, o_hart_reset, o_resume_req, o_halt_req} != exp_data) begin
					errors++;
					$display("ERR %0t: pattern %0d hart ports %b%b%b, expected %b",
						$time, p, o_hart_reset, o_resume_req, o_halt_req, exp_data[2:0]);
				end
			end
			32'd4: begin
				checks++;
				if (wb_last_adr != addr || wb_last_dat != exp_data || !wb_last_we) begin
					errors++;
					$display("ERR %0t: pattern %0d wb adr %h dat %h we %b, expected %h %h 1",
						$time, p, wb_last_adr, wb_last_dat, wb_last_we, addr, exp_data);
				end
			end
			default: begin
				errors++;
				$display("pattern %0d has an unknown op %0h", p, op);
			end
		endcase
	endtask

	initial begin : main
		logic [40:0] dout;
		int p;
		int cnt;
		rst_n = 1'b0;
		i_tck = 1'b0;
		i_tms = 1'b1;
		i_tdi = 1'b0;
		i_trst_n = 1'b1;
		for (p = 0; p < MAX_PAT*5; p++)
			pat_mem[p] = 32'hffff_ffff;
		// fill is the byte address of each word
		for (p = 0; p < 256; p++)
			mem[p] = 32'hd000_0000 | 32'(p << 2);
		$readmemh("test/dbg_patterns.txt", pat_mem);
		cnt = 0;
		while (cnt < MAX_PAT && pat_mem[cnt*5] != 32'hffff_ffff)
			cnt++;
		n_pat = cnt;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);
		checks++;
		if (o_wb_cyc || o_wb_stb || o_halt_req || o_resume_req || o_hart_reset || !o_tdo) begin
			errors++;
			$display("ERR %0t: outputs after reset cyc %b stb %b halt %b resume %b rst %b tdo %b",
				$time, o_wb_cyc, o_wb_stb, o_halt_req, o_resume_req, o_hart_reset, o_tdo);
		end
		if (n_pat == 0) begin
			errors++;
			$display("no patterns were read from the pattern file");
		end
		tap_reset();
		shift_dr('0, 32, dout);
		checks++;
		if (dout[31:0] != `DBG_IDCODE) begin
			errors++;
			$display("ERR %0t: idcode %h, expected %h", $time, dout[31:0], `DBG_IDCODE);
		end
		shift_ir(`IR_DMI);
		for (p = 0; p < n_pat; p++)
			run_pattern(p);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// two extra slots cover reset and the IDCODE scan
	initial begin : watchdog
		wait (n_pat > 0);
		repeat ((n_pat + 2) * CYC_PER_PAT) @(posedge clk);
		$display("timeout, the run did not finish in %0d clock cycles",
			(n_pat + 2) * CYC_PER_PAT);
		$display("tests failed");
		$finish;
	end

endmodule

/* test/dbg_patterns.txt */
// op addr data expect status in hex; op 1 DMI read, 2 DMI write, 3 hart ports
// {reset,resume,halt} in expect, 4 last Wishbone write with adr in addr and dat in expect
2 04 12345678 00000000 0
1 04 00000000 12345678 0
1 05 00000000 00000000 2
2 10 80000001 00000000 0
3 00 00000000 00000001 0
1 11 00000000 00000382 0
2 10 40000001 00000000 0
1 11 00000000 00030c82 0
3 00 00000000 00000000 0
1 10 00000000 00000001 0
2 39 00000100 00000000 0
2 3c cafef00d 00000000 0
4 100 00000000 cafef00d 0
2 39 00000104 00000000 0
2 3c 13579bdf 00000000 0
4 104 00000000 13579bdf 0
2 38 00140000 00000000 0
2 39 00000100 00000000 0
1 3c 00000000 cafef00d 0
1 38 00000000 20140404 0
2 39 00008000 00000000 0
1 38 00000000 20142404 0
1 3c 00000000 cafef00d 0
2 38 00142000 00000000 0
1 38 00000000 20140404 0
2 10 00000003 00000000 0
3 00 00000000 00000004 0
2 10 00000001 00000000 0
3 00 00000000 00000000 0

/* sources.f */
+incdir+hdl
hdl/dbg_pkg.sv
hdl/dmi_if.sv
hdl/dbg_reset_sync.sv
hdl/jtag_dtm.sv
hdl/debug_module.sv
hdl/sba_wb_master.sv
hdl/dbg_top.sv
test/tb_dbg_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_dbg_top -o sim_dbg

./obj_dir/sim_dbg > sim.log 2>&1 || true
cat sim.log

grep -qx "all tests passed" sim.log
